//--- linedraw_pkg.sv
// Shared types, colour palette and default raster geometry for the line-drawing display.
// Every design module imports this package in its header.

package linedraw_pkg;

    localparam int CORDW = 16;  // coordinate width

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [3:0] cidx_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } line_cmd_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pix_wr_t;

    // default geometry, kept small so a frame simulates quickly
    localparam int H_ACTIVE  = 64;
    localparam int H_FRONT   = 4;
    localparam int H_SYNC    = 8;
    localparam int H_BACK    = 4;
    localparam int V_ACTIVE  = 40;
    localparam int V_FRONT   = 2;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 2;
    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 16;
    localparam int FB_SCALE  = 2;
    localparam int LB_TOP    = 4;

    // 16 colours, 4 bits per channel, as {red, green, blue}
    localparam logic [11:0] PALETTE [16] = '{
        12'h000, 12'h235, 12'h825, 12'h085,  // black, navy, plum, teal
        12'hA53, 12'h655, 12'hCCC, 12'hFFE,  // brown, grey, silver, white
        12'hF04, 12'hFA0, 12'hFE2, 12'h0E3,  // red, orange, yellow, green
        12'h2AF, 12'h879, 12'hF7A, 12'hFCA   // blue, lavender, pink, peach
    };

    function automatic rgb_t palette_lookup(cidx_t cidx);
        return rgb_t'(PALETTE[cidx]);
    endfunction

endpackage

//--- display_timing.sv
// Raster scan generator: pixel position counters, active-high sync pulses,
// and single-cycle frame and line strobes that follow the counters.

module display_timing import linedraw_pkg::*; #(
    parameter int H_ACTIVE = linedraw_pkg::H_ACTIVE,
    parameter int H_FRONT  = linedraw_pkg::H_FRONT,
    parameter int H_SYNC   = linedraw_pkg::H_SYNC,
    parameter int H_BACK   = linedraw_pkg::H_BACK,
    parameter int V_ACTIVE = linedraw_pkg::V_ACTIVE,
    parameter int V_FRONT  = linedraw_pkg::V_FRONT,
    parameter int V_SYNC   = linedraw_pkg::V_SYNC,
    parameter int V_BACK   = linedraw_pkg::V_BACK
) (
    input  logic   clk_pix,
    input  logic   rst_n,
    output coord_t sx,
    output coord_t sy,
    output logic   hsync,
    output logic   vsync,
    output logic   frame,
    output logic   line
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam coord_t H_LAST   = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST   = coord_t'(V_TOTAL - 1);
    localparam coord_t HS_START = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t HS_END   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t VS_START = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t VS_END   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin
            sx <= '0;  // end of line
            sy <= (sy == V_LAST) ? coord_t'(0) : sy + coord_t'(1);
        end else begin
            sx <= sx + coord_t'(1);
        end
    end

    // decoded straight from the counters, so they line up with sx/sy
    always_comb begin
        hsync = (sx >= HS_START) && (sx < HS_END);
        vsync = (sy >= VS_START) && (sy < VS_END);
        line  = (sx == '0);
        frame = (sx == '0) && (sy == '0);
    end

    a_sx_range: assert property (@(posedge clk_pix) disable iff (!rst_n)
        sx < coord_t'(H_TOTAL));

endmodule

//--- line_drawer.sv
// Bresenham line drawer for all octants. A command is taken over a four-phase
// req/ack handshake, then one pixel per cycle goes out while the framebuffer is free.

module line_drawer import linedraw_pkg::*; (
    input  logic      clk_pix,
    input  logic      rst_n,
    input  line_cmd_t cmd,
    input  logic      cmd_req,
    input  logic      busy,
    output logic      cmd_ack,
    output pix_wr_t   wr,
    output logic      wr_en
);

    typedef logic signed [CORDW+2:0] err_t;  // headroom for doubled error
    typedef enum logic [1:0] {
        IDLE,
        DRAW,
        ACK
    } state_t;

    state_t state;
    coord_t end_x;
    coord_t end_y;
    logic   x_neg;  // step direction
    logic   y_neg;
    err_t   dx;     // always >= 0
    err_t   dy;     // always <= 0
    err_t   err;
    err_t   cmd_dx;
    err_t   cmd_dy;
    err_t   e2;
    err_t   err_next;
    logic   step_x;
    logic   step_y;
    logic   at_end;
    logic   start;
    logic   advance;

    // deltas of the incoming command, used once when it is latched
    always_comb begin
        if (cmd.x1 >= cmd.x0) begin
            cmd_dx = err_t'(cmd.x1) - err_t'(cmd.x0);
        end else begin
            cmd_dx = err_t'(cmd.x0) - err_t'(cmd.x1);
        end
        if (cmd.y1 >= cmd.y0) begin
            cmd_dy = err_t'(cmd.y0) - err_t'(cmd.y1);
        end else begin
            cmd_dy = err_t'(cmd.y1) - err_t'(cmd.y0);
        end
    end

    always_comb begin
        e2       = err <<< 1;
        step_x   = (e2 >= dy);
        step_y   = (e2 <= dx);
        err_next = err;
        if (step_x) begin
            err_next = err_next + dy;
        end
        if (step_y) begin
            err_next = err_next + dx;
        end
        at_end  = (wr.x == end_x) && (wr.y == end_y);
        start   = (state == IDLE) && cmd_req;
        advance = (state == DRAW) && !busy && !at_end;  // pixel taken, more to go
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            cmd_ack <= 1'b0;
            wr_en   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_req) begin
                        wr_en <= 1'b1;  // first point is the start point
                        state <= DRAW;
                    end
                end
                DRAW: begin
                    if (!busy && at_end) begin
                        wr_en   <= 1'b0;
                        cmd_ack <= 1'b1;
                        state   <= ACK;
                    end
                end
                ACK: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (start) begin
            wr.x    <= cmd.x0;
            wr.y    <= cmd.y0;
            wr.cidx <= cmd.cidx;
            end_x   <= cmd.x1;
            end_y   <= cmd.y1;
            x_neg   <= (cmd.x1 < cmd.x0);
            y_neg   <= (cmd.y1 < cmd.y0);
            dx      <= cmd_dx;
            dy      <= cmd_dy;
            err     <= cmd_dx + cmd_dy;
        end else if (advance) begin
            err <= err_next;
            if (step_x) begin
                wr.x <= x_neg ? wr.x - coord_t'(1) : wr.x + coord_t'(1);
            end
            if (step_y) begin
                wr.y <= y_neg ? wr.y - coord_t'(1) : wr.y + coord_t'(1);
            end
        end
    end

    a_hold_when_busy: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (wr_en && busy) |=> (wr_en && $stable(wr)));

    a_ack_needs_req: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $rose(cmd_ack) |-> cmd_req);

endmodule

//--- draw_sequencer.sv
// Issues the four edges of a border rectangle to the line drawer, starting on
// the first frame strobe after reset. draw_done stays high once all are drawn.

module draw_sequencer import linedraw_pkg::*; #(
    parameter int FB_WIDTH  = linedraw_pkg::FB_WIDTH,
    parameter int FB_HEIGHT = linedraw_pkg::FB_HEIGHT
) (
    input  logic      clk_pix,
    input  logic      rst_n,
    input  logic      frame,
    input  logic      cmd_ack,
    output line_cmd_t cmd,
    output logic      cmd_req,
    output logic      draw_done
);

    localparam coord_t X_MAX = coord_t'(FB_WIDTH - 1);
    localparam coord_t Y_MAX = coord_t'(FB_HEIGHT - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT_ACK,
        S_RELEASE,
        S_DONE
    } state_t;

    state_t     state;
    logic [1:0] edge_idx;  // 0 top, 1 right, 2 bottom, 3 left

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            edge_idx  <= '0;
            cmd_req   <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (frame) begin
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    cmd_req <= 1'b1;  // cmd settled a cycle ago
                    state   <= S_WAIT_ACK;
                end
                S_WAIT_ACK: begin
                    if (cmd_ack) begin
                        cmd_req <= 1'b0;
                        state   <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (!cmd_ack) begin
                        if (edge_idx == 2'd3) begin
                            draw_done <= 1'b1;
                            state     <= S_DONE;
                        end else begin
                            edge_idx <= edge_idx + 2'd1;
                            state    <= S_ISSUE;
                        end
                    end
                end
                default: state <= S_DONE;  // stays here until reset
            endcase
        end
    end

    // edges run clockwise, each starting where the last one ended
    always_comb begin
        case (edge_idx)
            2'd0: cmd = '{x0: '0, y0: '0, x1: X_MAX, y1: '0, cidx: 4'h8};
            2'd1: cmd = '{x0: X_MAX, y0: '0, x1: X_MAX, y1: Y_MAX, cidx: 4'hA};
            2'd2: cmd = '{x0: X_MAX, y0: Y_MAX, x1: '0, y1: Y_MAX, cidx: 4'hB};
            default: cmd = '{x0: '0, y0: Y_MAX, x1: '0, y1: '0, cidx: 4'hC};
        endcase
    end

    a_cmd_stable: assert property (@(posedge clk_pix) disable iff (!rst_n)
        cmd_req |-> $stable(cmd));

endmodule

//--- framebuffer.sv
// Colour-index framebuffer shown letterboxed and scaled up on the raster.
// Writes are refused while the read side scans the letterbox; colour follows sx/sy by one cycle.

module framebuffer import linedraw_pkg::*; #(
    parameter int FB_WIDTH  = linedraw_pkg::FB_WIDTH,
    parameter int FB_HEIGHT = linedraw_pkg::FB_HEIGHT,
    parameter int FB_SCALE  = linedraw_pkg::FB_SCALE,
    parameter int LB_TOP    = linedraw_pkg::LB_TOP
) (
    input  logic    clk_pix,
    input  logic    rst_n,
    input  coord_t  sx,
    input  coord_t  sy,
    input  pix_wr_t wr,
    input  logic    wr_en,
    output logic    busy,
    output rgb_t    rgb
);

    localparam int DEPTH = FB_WIDTH * FB_HEIGHT;
    localparam int ADDRW = $clog2(DEPTH);

    localparam coord_t LB_RIGHT  = coord_t'(FB_WIDTH * FB_SCALE);
    localparam coord_t LB_Y0     = coord_t'(LB_TOP);
    localparam coord_t LB_Y1     = coord_t'(LB_TOP + FB_HEIGHT * FB_SCALE);
    localparam coord_t FB_W      = coord_t'(FB_WIDTH);
    localparam coord_t FB_H      = coord_t'(FB_HEIGHT);
    localparam coord_t SCALE_DIV = coord_t'(FB_SCALE);

    cidx_t            mem [DEPTH];
    logic             lb_active;
    logic             wr_in;
    logic             wr_acc;
    coord_t           fb_x;
    coord_t           fb_y;
    logic [ADDRW-1:0] rd_addr;
    logic [ADDRW-1:0] wr_addr;

    // screen starts out black
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_comb begin
        lb_active = (sx >= coord_t'(0)) && (sx < LB_RIGHT) && (sy >= LB_Y0) && (sy < LB_Y1);
        busy      = lb_active;  // read port owns the memory here
        fb_x      = sx / SCALE_DIV;
        fb_y      = (sy - LB_Y0) / SCALE_DIV;
        rd_addr   = ADDRW'(fb_y * FB_W + fb_x);
    end

    always_comb begin
        wr_in   = (wr.x >= coord_t'(0)) && (wr.x < FB_W) &&
                  (wr.y >= coord_t'(0)) && (wr.y < FB_H);
        wr_acc  = wr_en && !busy && wr_in;  // off-screen writes dropped
        wr_addr = ADDRW'(wr.y * FB_W + wr.x);
    end

    always_ff @(posedge clk_pix) begin
        if (wr_acc) begin
            mem[wr_addr] <= wr.cidx;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= '0;
        end else begin
            rgb <= lb_active ? palette_lookup(mem[rd_addr]) : '0;  // black border
        end
    end

    a_no_write_when_busy: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (wr_en && busy && wr_in) |=> (mem[$past(wr_addr)] == $past(mem[wr_addr])));

endmodule

//--- linedraw_top.sv
// Line-drawing display top: timing, draw sequencer, Bresenham drawer and framebuffer.
// Sync and colour leave through registers, two cycles behind the raster counters.

module linedraw_top import linedraw_pkg::*; #(
    parameter int H_ACTIVE  = linedraw_pkg::H_ACTIVE,
    parameter int H_FRONT   = linedraw_pkg::H_FRONT,
    parameter int H_SYNC    = linedraw_pkg::H_SYNC,
    parameter int H_BACK    = linedraw_pkg::H_BACK,
    parameter int V_ACTIVE  = linedraw_pkg::V_ACTIVE,
    parameter int V_FRONT   = linedraw_pkg::V_FRONT,
    parameter int V_SYNC    = linedraw_pkg::V_SYNC,
    parameter int V_BACK    = linedraw_pkg::V_BACK,
    parameter int FB_WIDTH  = linedraw_pkg::FB_WIDTH,
    parameter int FB_HEIGHT = linedraw_pkg::FB_HEIGHT,
    parameter int FB_SCALE  = linedraw_pkg::FB_SCALE,
    parameter int LB_TOP    = linedraw_pkg::LB_TOP
) (
    input  logic clk_pix,
    input  logic rst_n,
    output logic hsync,
    output logic vsync,
    output rgb_t rgb,
    output logic draw_done
);

    coord_t    sx;
    coord_t    sy;
    logic      tim_hsync;
    logic      tim_vsync;
    logic      frame;
    line_cmd_t cmd;
    logic      cmd_req;
    logic      cmd_ack;
    pix_wr_t   wr;
    logic      wr_en;
    logic      fb_busy;
    rgb_t      fb_rgb;
    logic      hsync_p1;
    logic      vsync_p1;

    display_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) timing_i (
        .clk_pix, .rst_n, .sx, .sy,
        .hsync(tim_hsync), .vsync(tim_vsync), .frame, .line()
    );

    draw_sequencer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) seq_i (
        .clk_pix, .rst_n, .frame, .cmd_ack, .cmd, .cmd_req, .draw_done
    );

    line_drawer drawer_i (
        .clk_pix, .rst_n, .cmd, .cmd_req, .busy(fb_busy), .cmd_ack, .wr, .wr_en
    );

    framebuffer #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE), .LB_TOP(LB_TOP)
    ) fb_i (
        .clk_pix, .rst_n, .sx, .sy, .wr, .wr_en, .busy(fb_busy), .rgb(fb_rgb)
    );

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync_p1 <= 1'b0;
            vsync_p1 <= 1'b0;
            hsync    <= 1'b0;
            vsync    <= 1'b0;
            rgb      <= '0;
        end else begin
            hsync_p1 <= tim_hsync;  // matches framebuffer read latency
            vsync_p1 <= tim_vsync;
            hsync    <= hsync_p1;
            vsync    <= vsync_p1;
            rgb      <= fb_rgb;
        end
    end

endmodule

//--- tb_clock.sv
// Testbench clock and reset source for the line-drawing display.
// Reset is held low for a few cycles and released on a falling edge.

module tb_clock #(
    parameter int HALF_PERIOD  = 2,  // ns, 4 ns period
    parameter int RESET_CYCLES = 4
) (
    output logic clk_pix,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_pix = 1'b0;
        forever #(HALF_PERIOD) clk_pix = ~clk_pix;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_pix);
        rst_n <= 1'b1;  // lands after the negedge samplers
    end

endmodule

//--- tb_linedraw.sv
// Testbench for the line-drawing display. Follows the raster from the sync outputs,
// checks sync timing and draw_done, and compares two whole frames with a reference model.

module tb_linedraw import linedraw_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_TOTAL        = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL        = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int HS_START       = H_ACTIVE + H_FRONT;
    localparam int VS_START       = V_ACTIVE + V_FRONT;
    localparam int LB_RIGHT       = FB_WIDTH * FB_SCALE;
    localparam int LB_BOTTOM      = LB_TOP + FB_HEIGHT * FB_SCALE;
    localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + 4 * H_TOTAL;  // checks need about 4 frames

    logic clk_pix;
    logic rst_n;
    logic hsync;
    logic vsync;
    rgb_t rgb;
    logic draw_done;

    int   cycle_count = 0;     // posedges since time zero
    int   run_cycles  = 0;     // cycles since reset release
    logic hs_prev     = 1'b0;
    logic vs_prev     = 1'b0;
    logic h_locked    = 1'b0;  // px follows hsync
    logic v_locked    = 1'b0;  // py follows vsync
    int   px          = 0;
    int   py          = 0;
    int   hs_width    = 0;
    int   vs_width    = 0;
    logic done_seen   = 1'b0;
    int   pic_phase   = 0;     // 0 waiting, 1 first frame, 2 repeat frame, 3 finished
    rgb_t first_pic [FRAME_CYCLES];

    tb_clock clk_i (.clk_pix, .rst_n);

    linedraw_top dut_i (.clk_pix, .rst_n, .hsync, .vsync, .rgb, .draw_done);

    // border rectangle in the framebuffer, later edges drawn over earlier ones
    function automatic rgb_t expected_rgb(int x, int y, logic drawn);
        int    fx;
        int    fy;
        cidx_t idx;
        if (!drawn || x < 0 || x >= LB_RIGHT || y < LB_TOP || y >= LB_BOTTOM) begin
            return '0;
        end
        fx  = x / FB_SCALE;
        fy  = (y - LB_TOP) / FB_SCALE;
        idx = 4'h0;
        if (fy == 0) begin
            idx = 4'h8;  // top
        end
        if (fx == FB_WIDTH - 1) begin
            idx = 4'hA;  // right
        end
        if (fy == FB_HEIGHT - 1) begin
            idx = 4'hB;  // bottom
        end
        if (fx == 0) begin
            idx = 4'hC;  // left
        end
        return palette_lookup(idx);
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rgb(string name, rgb_t exp, rgb_t act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            fail_run($sformatf("CHECK FAILED %s: expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_idle_outputs(string when);
        check_bit($sformatf("hsync %s", when), 1'b0, hsync);
        check_bit($sformatf("vsync %s", when), 1'b0, vsync);
        check_bit($sformatf("draw_done %s", when), 1'b0, draw_done);
        check_rgb($sformatf("rgb %s", when), '0, rgb);
    endtask

    // output pixel position, pulse widths and periods, all from the sync edges
    task automatic follow_raster();
        if (h_locked) begin
            px = (px == H_TOTAL - 1) ? 0 : px + 1;
            if (px == 0 && v_locked) begin
                py = (py == V_TOTAL - 1) ? 0 : py + 1;
            end
        end
        if (hsync && !hs_prev) begin
            if (h_locked) begin
                check_count("hsync rise pixel", HS_START, px);  // one line total later
            end
            px       = HS_START;
            h_locked = 1'b1;
        end
        if (vsync && !vs_prev) begin
            if (v_locked) begin
                check_count("vsync rise line", VS_START, py);
            end
            check_count("vsync rise pixel", 0, px);
            py       = VS_START;
            v_locked = 1'b1;
        end
        if (hsync) begin
            hs_width = hs_width + 1;
        end else if (hs_prev) begin
            check_count("hsync width", H_SYNC, hs_width);
            hs_width = 0;
        end
        if (vsync) begin
            vs_width = vs_width + 1;
        end else if (vs_prev) begin
            check_count("vsync width", V_SYNC * H_TOTAL, vs_width);
            vs_width = 0;
        end
        hs_prev = hsync;
        vs_prev = vsync;
    endtask

    task automatic check_draw_done();
        if (done_seen) begin
            check_bit("draw_done held high", 1'b1, draw_done);
        end
        if (draw_done) begin
            done_seen = 1'b1;
        end
        if (run_cycles == 2 * FRAME_CYCLES) begin
            check_bit("draw_done by third frame", 1'b1, draw_done);
        end
    endtask

    task automatic check_pixel();
        rgb_t  exp;
        string where;
        if (h_locked && v_locked && px == 0 && py == 0) begin
            if (pic_phase == 0 && done_seen) begin
                pic_phase = 1;
            end else if (pic_phase == 1 || pic_phase == 2) begin
                pic_phase = pic_phase + 1;
            end
        end
        if (!done_seen) begin
            // black everywhere until the border is complete
            exp   = expected_rgb(px, py, done_seen);
            where = $sformatf("rgb while drawing, cycle %0d", run_cycles);
            check_rgb(where, exp, rgb);
        end else if (pic_phase == 1 || pic_phase == 2) begin
            exp   = expected_rgb(px, py, done_seen);
            where = $sformatf("frame %0d pixel (%0d,%0d)", pic_phase, px, py);
            check_rgb(where, exp, rgb);
            if (pic_phase == 1) begin
                first_pic[py * H_TOTAL + px] = rgb;
            end else begin
                check_rgb({where, " repeat"}, first_pic[py * H_TOTAL + px], rgb);
            end
        end
    endtask

    // outputs move on the rising edge, so everything is sampled on the falling one
    always @(negedge clk_pix) begin
        if (!rst_n) begin
            check_idle_outputs("in reset");
        end else begin
            run_cycles = run_cycles + 1;
            if (run_cycles == 1) begin
                check_idle_outputs("after reset");
            end
            follow_raster();
            check_draw_done();
            check_pixel();
        end
    end

    always @(posedge clk_pix) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: the frame checks did not finish in %0d cycles",
                               TIMEOUT_CYCLES));
        end
    end

    initial begin
        wait (pic_phase == 3);
        $display("No errors");
        $finish;
    end

endmodule

//--- linedraw.f
linedraw_pkg.sv
display_timing.sv
line_drawer.sv
draw_sequencer.sv
framebuffer.sv
linedraw_top.sv
tb_clock.sv
tb_linedraw.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f linedraw.f --top-module tb_linedraw -o sim_linedraw
./obj_dir/sim_linedraw | tee sim.log
if grep -q '^No errors$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
